//--- logic/vga_sprite_pkg.sv
// shared timing and size constants plus the packed types for the sprite engine
// every file refers to these by scoped name
package vga_sprite_pkg;

    // horizontal timing, counted in 50 MHz clocks
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = 1600;

    // vertical timing, counted in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = 525;

    localparam int OBJ_COUNT    = 8;
    localparam int SPRITE_W     = 16;
    localparam int SPRITE_H     = 16;
    localparam int SPRITE_COUNT = 4;
    localparam int ROM_DEPTH    = 1024;
    localparam int PIPE_DEPTH   = 4;    // counters to pins

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // same bit order as host writedata[31:1]
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [5:0]  sprite;
        logic        active;
    } obj_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
    } pos_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic blank_n;
        logic vclk;
    } sync_t;

    typedef struct packed {
        logic       hit;
        logic [9:0] rom_addr;
        sync_t      sync;
    } match_t;

endpackage

//--- logic/video_timing.sv
// 640x480 VGA raster counters, two clocks per pixel
// sync and blank are decoded straight from the counts
`timescale 1ns/1ps

module video_timing (
    input  logic                  clk,
    input  logic                  reset,
    output vga_sprite_pkg::pos_t  pos,
    output vga_sprite_pkg::sync_t sync
);

    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        end_of_line;
    logic        end_of_frame;

    assign end_of_line  = hcount == 11'(vga_sprite_pkg::H_TOTAL - 1);
    assign end_of_frame = vcount == 10'(vga_sprite_pkg::V_TOTAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_frame ? 10'd0 : vcount + 10'd1;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    assign pos.hcount = hcount;
    assign pos.vcount = vcount;

    // both syncs active low
    assign sync.hs = !(hcount >= 11'(vga_sprite_pkg::H_ACTIVE + vga_sprite_pkg::H_FRONT) &&
        hcount < 11'(vga_sprite_pkg::H_ACTIVE + vga_sprite_pkg::H_FRONT + vga_sprite_pkg::H_SYNC));
    assign sync.vs = !(vcount >= 10'(vga_sprite_pkg::V_ACTIVE + vga_sprite_pkg::V_FRONT) &&
        vcount < 10'(vga_sprite_pkg::V_ACTIVE + vga_sprite_pkg::V_FRONT + vga_sprite_pkg::V_SYNC));
    assign sync.blank_n = hcount < 11'(vga_sprite_pkg::H_ACTIVE) &&
                          vcount < 10'(vga_sprite_pkg::V_ACTIVE);
    assign sync.vclk = hcount[0];    // 25 MHz pixel clock

    a_counts_in_range: assert property (@(posedge clk) disable iff (reset)
        hcount < 11'(vga_sprite_pkg::H_TOTAL) && vcount < 10'(vga_sprite_pkg::V_TOTAL));

endmodule

//--- logic/object_regs.sv
// host register file: background color at address 0, objects at 1..8
// chip-select write, taken on the clock edge with no wait state
`timescale 1ns/1ps

module object_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 chipselect,
    input  logic                 write,
    input  logic [6:0]           address,
    input  logic [31:0]          writedata,
    output vga_sprite_pkg::obj_t objs [vga_sprite_pkg::OBJ_COUNT],
    output vga_sprite_pkg::rgb_t background
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background <= 24'h008000;    // dark green
            for (int i = 0; i < vga_sprite_pkg::OBJ_COUNT; i++) begin
                objs[i] <= '0;
            end
        end else if (chipselect && write) begin
            if (address == 7'd0) begin
                background <= writedata[23:0];
            end
            // x, y, sprite, active line up with bits 31..1, bit 0 unused
            for (int i = 0; i < vga_sprite_pkg::OBJ_COUNT; i++) begin
                if (address == 7'(i + 1)) begin
                    objs[i] <= writedata[31:1];
                end
            end
        end
    end

endmodule

//--- logic/object_match.sv
// first pipeline stage: finds the lowest-numbered active object over the pixel
// and forms its sprite ROM address, registered along with the sync bits
`timescale 1ns/1ps

module object_match (
    input  logic                   clk,
    input  logic                   reset,
    input  vga_sprite_pkg::pos_t   pos,
    input  vga_sprite_pkg::sync_t  sync,
    input  vga_sprite_pkg::obj_t   objs [vga_sprite_pkg::OBJ_COUNT],
    output vga_sprite_pkg::match_t match
);

    localparam int SEL_W = $clog2(vga_sprite_pkg::SPRITE_COUNT);

    logic [10:0] px;
    logic [10:0] py;
    logic        hit;
    logic [9:0]  rom_addr;

    assign px = {1'b0, pos.hcount[10:1]};
    assign py = {1'b0, pos.vcount};

    always_comb begin
        logic [10:0] ox;
        logic [10:0] oy;
        logic [10:0] dx;
        logic [10:0] dy;
        hit = 1'b0;
        rom_addr = '0;
        // scan downward so the lowest index is the last to overwrite
        for (int i = vga_sprite_pkg::OBJ_COUNT - 1; i >= 0; i--) begin
            ox = {1'b0, objs[i].x[9:0]};
            oy = {1'b0, objs[i].y[9:0]};
            dx = px - ox;
            dy = py - oy;
            if (objs[i].active && px >= ox && dx < 11'(vga_sprite_pkg::SPRITE_W) &&
                py >= oy && dy < 11'(vga_sprite_pkg::SPRITE_H)) begin
                hit = 1'b1;
                rom_addr = {objs[i].sprite[SEL_W-1:0], dy[3:0], dx[3:0]};    // sprite*256 + row*16 + col
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            match <= '0;
        end else begin
            match.hit <= hit;
            match.rom_addr <= rom_addr;
            match.sync <= sync;
        end
    end

endmodule

//--- logic/sprite_fetch.sv
// pattern ROM read then palette lookup, one clock each
// hit and sync ride alongside so all three leave aligned
`timescale 1ns/1ps

module sprite_fetch (
    input  logic                   clk,
    input  logic                   reset,
    input  vga_sprite_pkg::match_t match,
    output logic                   hit,
    output vga_sprite_pkg::sync_t  sync,
    output vga_sprite_pkg::rgb_t   color
);

    logic [7:0]            rom [vga_sprite_pkg::ROM_DEPTH];
    logic [7:0]            pattern;
    logic                  hit_q;
    vga_sprite_pkg::sync_t sync_q;

    initial $readmemh("logic/sprites.hex", rom);    // four 16x16 sprites

    // 6x6x6 color cube, anything past 215 is black
    function automatic vga_sprite_pkg::rgb_t palette(input logic [7:0] idx);
        vga_sprite_pkg::rgb_t c;
        int i;
        i = int'(idx);
        c = '0;
        if (i < 216) begin
            c.r = 8'((i / 36) * 'h33);
            c.g = 8'(((i / 6) % 6) * 'h33);
            c.b = 8'((i % 6) * 'h33);
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pattern <= '0;
            hit_q <= 1'b0;
            sync_q <= '0;
            hit <= 1'b0;
            sync <= '0;
            color <= '0;
        end else begin
            pattern <= rom[match.rom_addr];
            hit_q <= match.hit;
            sync_q <= match.sync;
            color <= palette(pattern);
            hit <= hit_q;
            sync <= sync_q;
        end
    end

endmodule

//--- logic/pixel_mixer.sv
// last stage: picks sprite, background or black and registers the VGA pins
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hit,
    input  vga_sprite_pkg::sync_t sync,
    input  vga_sprite_pkg::rgb_t  color,
    input  vga_sprite_pkg::rgb_t  background,
    output logic [7:0]            vga_r,
    output logic [7:0]            vga_g,
    output logic [7:0]            vga_b,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output logic                  vga_blank_n,
    output logic                  vga_clk
);

    vga_sprite_pkg::rgb_t pixel;

    always_comb begin
        if (!sync.blank_n) begin
            pixel = '0;
        end else if (hit && color != '0) begin
            pixel = color;
        end else begin
            pixel = background;    // black sprite pixels are see-through
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs <= 1'b0;
            vga_vs <= 1'b0;
            vga_blank_n <= 1'b0;
            vga_clk <= 1'b0;
        end else begin
            {vga_r, vga_g, vga_b} <= pixel;
            vga_hs <= sync.hs;
            vga_vs <= sync.vs;
            vga_blank_n <= sync.blank_n;
            vga_clk <= sync.vclk;
        end
    end

    a_black_in_blank: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'h0);

endmodule

//--- logic/vga_sprite_top.sv
// sprite display engine top: host write port in, VGA pins out
// counters feed a four-clock match, fetch and mix pipeline
`timescale 1ns/1ps

module vga_sprite_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [6:0]  address,
    input  logic [31:0] writedata,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b
);

    vga_sprite_pkg::pos_t   pos;
    vga_sprite_pkg::sync_t  raw_sync;
    vga_sprite_pkg::obj_t   objs [vga_sprite_pkg::OBJ_COUNT];
    vga_sprite_pkg::rgb_t   background;
    vga_sprite_pkg::match_t match;
    logic                   fetch_hit;
    vga_sprite_pkg::sync_t  fetch_sync;
    vga_sprite_pkg::rgb_t   fetch_color;

    video_timing i_video_timing (
        .clk   (clk),
        .reset (reset),
        .pos   (pos),
        .sync  (raw_sync)
    );

    object_regs i_object_regs (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .objs       (objs),
        .background (background)
    );

    object_match i_object_match (
        .clk   (clk),
        .reset (reset),
        .pos   (pos),
        .sync  (raw_sync),
        .objs  (objs),
        .match (match)
    );

    sprite_fetch i_sprite_fetch (
        .clk   (clk),
        .reset (reset),
        .match (match),
        .hit   (fetch_hit),
        .sync  (fetch_sync),
        .color (fetch_color)
    );

    pixel_mixer i_pixel_mixer (
        .clk         (clk),
        .reset       (reset),
        .hit         (fetch_hit),
        .sync        (fetch_sync),
        .color       (fetch_color),
        .background  (background),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk)
    );

endmodule

//--- testbench/tb_clock.sv
// free-running 50 MHz clock for the testbench
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 10ns;    // 20 ns period

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- testbench/tb_vga_sprite.sv
// testbench for the sprite engine: random host writes in vertical blanking,
// a pixel model of each frame, and every VGA pin compared on every clock
`timescale 1ns/1ps

module tb_vga_sprite #(
    parameter logic [31:0] SEED = 32'hfb3e_575b
);

    localparam int LAG         = 4;    // counter value to pins
    localparam int FRAMES      = 5;
    localparam int FRAME_NS    = 1600 * 525 * 20;
    localparam int WATCHDOG_NS = FRAMES * FRAME_NS + 100_000;

    typedef struct packed {
        logic [10:0] h;
        logic [9:0]  v;
        logic [27:0] pins;    // hs, vs, blank_n, vclk, r, g, b
    } expect_t;

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [6:0]  address;
    logic [31:0] writedata;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;

    logic [7:0]           rom [1024];
    vga_sprite_pkg::rgb_t pal [256];
    vga_sprite_pkg::rgb_t bg;
    vga_sprite_pkg::obj_t objs [8];
    expect_t              pending [$];
    logic [10:0]          hc;
    logic [9:0]           vc;
    string                test_name;
    int                   covered;
    int                   see_through;

    tb_clock i_tb_clock (.clk(clk));

    vga_sprite_top i_vga_sprite_top (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    task automatic abort_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run({name, " does not match the expected value"});
        end
    endtask

    // expected pins for one raster position
    task automatic predict(input logic [10:0] h, input logic [9:0] v,
                           output logic [27:0] pins);
        vga_sprite_pkg::rgb_t c;
        logic blank_n;
        int px;
        int py;
        int ox;
        int oy;
        int addr;
        int winner;
        blank_n = h < 11'd1280 && v < 10'd480;
        px = int'(h) / 2;
        py = int'(v);
        winner = -1;
        c = '0;
        if (blank_n) begin
            c = bg;
            for (int i = 7; i >= 0; i--) begin
                ox = int'(objs[i].x[9:0]);
                oy = int'(objs[i].y[9:0]);
                if (objs[i].active && px >= ox && px < ox + 16 && py >= oy && py < oy + 16)
                    winner = i;
            end
        end
        if (winner >= 0) begin
            ox = int'(objs[winner].x[9:0]);
            oy = int'(objs[winner].y[9:0]);
            addr = int'(objs[winner].sprite[1:0]) * 256 + (py - oy) * 16 + (px - ox);
            covered++;
            if (pal[rom[addr]] == 24'h0)
                see_through++;    // transparent, background stays
            else
                c = pal[rom[addr]];
        end
        pins = {!(h >= 11'd1312 && h <= 11'd1503), !(v == 10'd490 || v == 10'd491),
                blank_n, h[0], c};
    endtask

    // compare at the current falling edge, then advance the model raster
    task automatic sample();
        expect_t     e;
        logic [27:0] actual;
        actual = {vga_hs, vga_vs, vga_blank_n, vga_clk, vga_r, vga_g, vga_b};
        e.h = hc;
        e.v = vc;
        predict(hc, vc, e.pins);
        pending.push_back(e);
        if (pending.size() > LAG) begin
            e = pending.pop_front();
            check($sformatf("%s at h=%0d v=%0d", test_name, e.h, e.v), 32'(e.pins), 32'(actual));
        end else begin
            check($sformatf("%s pipeline fill", test_name), 32'h0, 32'(actual));
        end
        if (hc == 11'd1599) begin
            hc = '0;
            vc = (vc == 10'd524) ? 10'd0 : vc + 10'd1;
        end else begin
            hc = hc + 11'd1;
        end
    endtask

    task automatic step();
        sample();
        @(negedge clk);
    endtask

    task automatic run_to(input int h, input int v);
        while (!(hc == 11'(h) && vc == 10'(v)))
            step();
    endtask

    task automatic run_frame();
        run_to(0, 0);
        run_to(0, 480);    // stop at the next vertical blanking
    endtask

    task automatic host_write(input logic [6:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write = 1'b1;
        address = addr;
        writedata = data;
        sample();
        if (addr == 7'd0) begin
            bg = data[23:0];
        end else if (addr <= 7'd8) begin
            objs[addr - 1].x = data[31:20];
            objs[addr - 1].y = data[19:8];
            objs[addr - 1].sprite = data[7:2];
            objs[addr - 1].active = data[1];
        end
        @(negedge clk);
        chipselect = 1'b0;
        write = 1'b0;
    endtask

    function automatic logic [31:0] object_word(input int x, input int y, input logic active);
        logic [5:0] sprite;
        sprite = 6'($urandom());
        return {12'(x), 12'(y), sprite, active, 1'($urandom())};    // bit 0 is don't-care
    endfunction

    initial begin
        #(WATCHDOG_NS * 1ns);
        abort_run("watchdog expired before the last frame finished");
    end

    initial begin
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = '0;
        writedata = '0;
        hc = '0;
        vc = '0;
        covered = 0;
        see_through = 0;
        bg = 24'h008000;
        for (int i = 0; i < 8; i++)
            objs[i] = '0;
        void'($urandom(SEED));
        $readmemh("logic/sprites.hex", rom);
        for (int i = 0; i < 256; i++)
            pal[i] = '0;
        for (int r = 0; r < 6; r++)
            for (int g = 0; g < 6; g++)
                for (int b = 0; b < 6; b++)
                    pal[r * 36 + g * 6 + b] = {8'(r * 51), 8'(g * 51), 8'(b * 51)};
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test_name = "sync_blank";
        run_to(0, 480);

        test_name = "background";
        host_write(7'd0, $urandom());
        run_frame();

        test_name = "sprites";
        for (int i = 0; i < 8; i++)
            host_write(7'(i + 1), object_word($urandom_range(624), $urandom_range(464), 1'b1));
        run_frame();

        // clustered so objects overlap, object 0 switched off over the cluster
        test_name = "priority";
        host_write(7'd1, object_word(308, 208, 1'b0));
        for (int i = 1; i < 8; i++)
            host_write(7'(i + 1), object_word(300 + $urandom_range(23),
                                              200 + $urandom_range(23), 1'b1));
        for (int k = 0; k < 6; k++)
            host_write(7'(9 + $urandom_range(118)), $urandom());
        run_frame();

        check("coverage", 32'd1, 32'(covered > 0));
        check("transparency", 32'd1, 32'(see_through > 0));
        $display("Test passed");
        $finish;
    end

endmodule

//--- logic/sprites.hex
// pattern ROM, one sprite row of 16 palette indices per line, column 0 first
// lines 1-16 sprite 0, 17-32 sprite 1, 33-48 sprite 2, 49-64 sprite 3
00 00 00 00 00 25 26 27 28 29 2A 00 00 00 00 00
00 00 00 2B 2C 2D 2E 2F 30 31 32 33 34 00 00 00
00 00 32 33 34 35 36 37 38 39 3A 3B 3C 3D 00 00
00 39 3A 3B 3C 3D 3E 3F 40 41 42 43 44 45 46 00
00 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 00
48 49 4A 4B 4C 4D 4E 4F 50 51 52 53 54 55 56 57
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
58 59 5A 5B 5C 5D 5E 5F 60 61 62 63 64 65 66 67
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
00 79 7A 7B 7C 7D 7E 7F 80 81 82 83 84 85 86 00
00 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 00
00 00 8A 8B 8C 8D 8E 8F 90 91 92 93 94 95 00 00
00 00 00 93 94 95 96 97 98 99 9A 9B 9C 00 00 00
00 00 00 00 00 9D 9E 9F A0 A1 A2 00 00 00 00 00
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
68 69 6A 6B 6C 6D 6E 6F 70 71 72 73 74 75 76 77
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
78 79 7A 7B 7C 7D 7E 7F 80 81 82 83 84 85 86 87
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
88 89 8A 8B 8C 8D 8E 8F 90 91 92 93 94 95 96 97
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
98 99 9A 9B 9C 9D 9E 9F A0 A1 A2 A3 A4 A5 A6 A7
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
A8 A9 AA AB AC AD AE AF B0 B1 B2 B3 B4 B5 B6 B7
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
B8 B9 BA BB BC BD BE BF C0 C1 C2 C3 C4 C5 C6 C7
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
C8 C9 CA CB CC CD CE CF D0 D1 D2 D3 D4 D5 D6 D7
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
D8 D9 DA DB DC DD DE DF E0 E1 E2 E3 E4 E5 E6 E7
00 00 00 00 00 09 0A 0B 0C 0D 0E 00 00 00 00 00
00 00 00 00 00 11 12 13 14 15 16 00 00 00 00 00
00 00 00 00 00 19 1A 1B 1C 1D 1E 00 00 00 00 00
00 00 00 00 00 21 22 23 24 25 26 00 00 00 00 00
00 00 00 00 00 29 2A 2B 2C 2D 2E 00 00 00 00 00
2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B
34 35 36 37 38 39 3A 3B 3C 3D 3E 3F 40 41 42 43
3C 3D 3E 3F 40 41 42 43 44 45 46 47 48 49 4A 4B
44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53
4C 4D 4E 4F 50 51 52 53 54 55 56 57 58 59 5A 5B
54 55 56 57 58 59 5A 5B 5C 5D 5E 5F 60 61 62 63
00 00 00 00 00 61 62 63 64 65 66 00 00 00 00 00
00 00 00 00 00 69 6A 6B 6C 6D 6E 00 00 00 00 00
00 00 00 00 00 71 72 73 74 75 76 00 00 00 00 00
00 00 00 00 00 79 7A 7B 7C 7D 7E 00 00 00 00 00
00 00 00 00 00 81 82 83 84 85 86 00 00 00 00 00
C0 C0 C0 C0 F1 F1 F1 F1 C2 C2 C2 C2 F3 F3 F3 F3
C0 C0 C0 C0 F1 F1 F1 F1 C2 C2 C2 C2 F3 F3 F3 F3
C0 C0 C0 C0 F1 F1 F1 F1 C2 C2 C2 C2 F3 F3 F3 F3
C0 C0 C0 C0 F1 F1 F1 F1 C2 C2 C2 C2 F3 F3 F3 F3
F4 F4 F4 F4 C5 C5 C5 C5 F6 F6 F6 F6 C7 C7 C7 C7
F4 F4 F4 F4 C5 C5 C5 C5 F6 F6 F6 F6 C7 C7 C7 C7
F4 F4 F4 F4 C5 C5 C5 C5 F6 F6 F6 F6 C7 C7 C7 C7
F4 F4 F4 F4 C5 C5 C5 C5 F6 F6 F6 F6 C7 C7 C7 C7
C8 C8 C8 C8 F9 F9 F9 F9 CA CA CA CA FB FB FB FB
C8 C8 C8 C8 F9 F9 F9 F9 CA CA CA CA FB FB FB FB
C8 C8 C8 C8 F9 F9 F9 F9 CA CA CA CA FB FB FB FB
C8 C8 C8 C8 F9 F9 F9 F9 CA CA CA CA FB FB FB FB
FC FC FC FC CD CD CD CD FE FE FE FE CF CF CF CF
FC FC FC FC CD CD CD CD FE FE FE FE CF CF CF CF
FC FC FC FC CD CD CD CD FE FE FE FE CF CF CF CF
FC FC FC FC CD CD CD CD FE FE FE FE CF CF CF CF

//--- all.f
logic/vga_sprite_pkg.sv
logic/video_timing.sv
logic/object_regs.sv
logic/object_match.sv
logic/sprite_fetch.sv
logic/pixel_mixer.sv
logic/vga_sprite_top.sv
testbench/tb_clock.sv
testbench/tb_vga_sprite.sv

//--- Makefile
# Verilator flow for the sprite engine, run from the project root
VERILATOR ?= verilator
TOP       ?= tb_vga_sprite
RTL_TOP   ?= vga_sprite_top
SEED      ?= fb3e575b
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f all.f

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-GSEED=32\'h$(SEED) -Mdir $(BUILD) -f all.f
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
